//--- design/fsb_pkg.sv
`default_nettype none

package fsb_pkg;

  // ring packet geometry, ten bytes on the wire
  localparam int ring_bytes_lp = 10;
  localparam int ring_width_lp = ring_bytes_lp * 8;

  // first byte is header, the rest is payload
  localparam int payload_bytes_lp = ring_bytes_lp - 1;

  // client nodes on the hub
  localparam int num_nodes_lp = 2;
  localparam int sum_node_id_lp = 0;
  localparam int swap_node_id_lp = 1;

  // both nodes come up disabled
  localparam logic [num_nodes_lp-1:0] enabled_at_start_lp = '0;

  // control opcodes
  // other encodings fall through and do nothing
  typedef enum logic [2:0]
  {
    op_enable  = 3'd1,
    op_disable = 3'd2,
    op_reset   = 3'd3
  } fsb_opcode_e;

  // data view, cmd == 0
  // byte 0 of data is the least significant
  typedef struct packed
  {
    logic [3:0]                       destid;
    logic                             cmd;
    logic [2:0]                       pad;
    logic [payload_bytes_lp-1:0][7:0] data;
  } fsb_data_s;

  // control view, cmd == 1
  // header layout matches the data view
  typedef struct packed
  {
    logic [3:0]               destid;
    logic                     cmd;
    fsb_opcode_e              opcode;
    logic [ring_width_lp-9:0] pad;
  } fsb_ctrl_s;

  // one ring word, decoded by cmd
  typedef union packed
  {
    fsb_data_s data;
    fsb_ctrl_s ctrl;
  } fsb_pkt_u;

  // per node control from the dispatcher
  typedef struct packed
  {
    logic en;
    logic reset;
  } fsb_node_ctrl_s;

endpackage

`default_nettype wire

//--- design/fsb_dispatch.sv
`default_nettype none

module fsb_dispatch
  import fsb_pkg::*;
(
  input  logic                    core_clk_i,
  input  logic                    rst_i,

  // packets from the link side
  input  logic                    asm_v_i,
  input  fsb_pkt_u                asm_data_i,
  output logic                    asm_yumi_o,

  // toward the client nodes
  output logic [num_nodes_lp-1:0] node_v_o,
  output fsb_pkt_u                node_data_o,
  input  logic [num_nodes_lp-1:0] node_ready_i,
  output fsb_node_ctrl_s          node_ctrl_o [num_nodes_lp-1:0]
);

  // node enable and one-shot reset state
  logic [num_nodes_lp-1:0] en_r;
  logic [num_nodes_lp-1:0] reset_r;

  // header decode
  logic is_ctrl;
  logic dest_ok;
  logic dest_sel;

  assign is_ctrl  = asm_data_i.data.cmd;
  // destid 2 and up has no node behind it
  assign dest_ok  = (asm_data_i.data.destid < num_nodes_lp);
  // only meaningful when dest_ok
  assign dest_sel = asm_data_i.data.destid[0];

  // payload is broadcast, the strobe picks the node
  assign node_data_o = asm_data_i;

  always_comb
  begin
    for (int n = 0; n < num_nodes_lp; n++)
    begin
      // valid only toward an enabled, addressed node
      node_v_o[n] = asm_v_i & ~is_ctrl & dest_ok & (dest_sel == n[0]) & en_r[n];
      node_ctrl_o[n].en    = en_r[n];
      node_ctrl_o[n].reset = reset_r[n];
    end
  end

  // consume at once unless a live data packet waits on its node
  // control, bad destid and disabled targets all drain immediately
  assign asm_yumi_o = asm_v_i
                    & (is_ctrl | ~dest_ok | ~en_r[dest_sel] | node_ready_i[dest_sel]);

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      en_r    <= enabled_at_start_lp;
      reset_r <= '0;
    end
    else
    begin
      // reset pulse lasts a single cycle
      reset_r <= '0;
      if (asm_v_i & is_ctrl & dest_ok)
      begin
        case (asm_data_i.ctrl.opcode)
          op_enable:
          begin
            en_r[dest_sel] <= 1'b1;
          end
          op_disable:
          begin
            en_r[dest_sel] <= 1'b0;
          end
          op_reset:
          begin
            reset_r[dest_sel] <= 1'b1;
          end
          default:
          begin
            // unknown opcode, ignored
          end
        endcase
      end
    end
  end

  // a waiting packet stays offered and unchanged until it is taken
  assert property (@(posedge core_clk_i) disable iff (rst_i)
    (asm_v_i && !asm_yumi_o) |=> (asm_v_i && $stable(asm_data_i)));

endmodule

`default_nettype wire

//--- design/fsb_sum_node.sv
`default_nettype none

module fsb_sum_node
  import fsb_pkg::*;
(
  input  logic           core_clk_i,
  input  logic           rst_i,
  input  fsb_node_ctrl_s node_ctrl_i,

  // from the dispatcher
  input  logic           v_i,
  input  fsb_pkt_u       data_i,
  output logic           ready_o,

  // to the return arbiter
  output logic           v_o,
  output fsb_pkt_u       data_o,
  input  logic           yumi_i
);

  // one-deep output register
  logic     v_r;
  fsb_pkt_u data_r;
  // packets handled since the last reset, wraps at 256
  logic [7:0] count_r;

  logic        accept;
  logic [15:0] sum;
  fsb_pkt_u    result;

  // room if empty or draining this cycle
  assign ready_o = ~v_r | yumi_i;
  assign accept  = v_i & ready_o & node_ctrl_i.en;

  // byte sum and result packing
  always_comb
  begin
    sum = '0;
    for (int i = 0; i < payload_bytes_lp; i++)
    begin
      sum = sum + 16'(data_i.data.data[i]);
    end
    // header passes through untouched
    result = data_i;
    result.data.data    = '0;
    result.data.data[0] = sum[7:0];
    result.data.data[1] = sum[15:8];
    // count includes this packet
    result.data.data[2] = count_r + 8'd1;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i | node_ctrl_i.reset)
    begin
      v_r     <= 1'b0;
      count_r <= '0;
    end
    else if (accept)
    begin
      v_r     <= 1'b1;
      count_r <= count_r + 8'd1;
    end
    else if (yumi_i)
    begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (accept)
    begin
      data_r <= result;
    end
  end

  assign v_o    = v_r;
  assign data_o = data_r;

  // arbiter only takes what the node offers
  assert property (@(posedge core_clk_i) disable iff (rst_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

//--- design/fsb_swap_node.sv
`default_nettype none

module fsb_swap_node
  import fsb_pkg::*;
(
  input  logic           core_clk_i,
  input  logic           rst_i,
  input  fsb_node_ctrl_s node_ctrl_i,

  // from the dispatcher
  input  logic           v_i,
  input  fsb_pkt_u       data_i,
  output logic           ready_o,

  // to the return arbiter
  output logic           v_o,
  output fsb_pkt_u       data_o,
  input  logic           yumi_i
);

  // one-deep output register
  logic     v_r;
  fsb_pkt_u data_r;

  logic     accept;
  fsb_pkt_u result;

  assign ready_o = ~v_r | yumi_i;
  assign accept  = v_i & ready_o & node_ctrl_i.en;

  // mirror the payload, byte k takes byte 8-k
  always_comb
  begin
    result = data_i;
    for (int k = 0; k < payload_bytes_lp; k++)
    begin
      result.data.data[k] = data_i.data.data[payload_bytes_lp-1-k];
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i | node_ctrl_i.reset)
    begin
      v_r <= 1'b0;
    end
    else if (accept)
    begin
      v_r <= 1'b1;
    end
    else if (yumi_i)
    begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (accept)
    begin
      data_r <= result;
    end
  end

  assign v_o    = v_r;
  assign data_o = data_r;

  assert property (@(posedge core_clk_i) disable iff (rst_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

//--- design/fsb_return_arb.sv
`default_nettype none

module fsb_return_arb
  import fsb_pkg::*;
(
  input  logic                    core_clk_i,
  input  logic                    rst_i,

  // from the client nodes
  input  logic [num_nodes_lp-1:0] node_v_i,
  input  fsb_pkt_u                node_data_i [num_nodes_lp-1:0],
  output logic [num_nodes_lp-1:0] node_yumi_o,

  // outgoing stream
  output logic                    asm_v_o,
  output fsb_pkt_u                asm_data_o,
  input  logic                    asm_ready_i
);

  // output register
  logic     out_v_r;
  fsb_pkt_u out_data_r;
  // round-robin pointer, set means node 1 goes first on a tie
  logic     rr_r;

  logic                    load_ok;
  logic                    both_v;
  logic [num_nodes_lp-1:0] grant;
  logic                    win;
  fsb_pkt_u                pick;

  // register can take a new word when empty or handing off
  assign load_ok = ~out_v_r | asm_ready_i;
  assign both_v  = &node_v_i;

  always_comb
  begin
    if (both_v)
    begin
      grant = rr_r ? 2'b10 : 2'b01;
    end
    else
    begin
      grant = node_v_i;
    end
  end

  assign node_yumi_o = load_ok ? grant : '0;
  assign win         = grant[1];

  // stamp the producing node index into destid
  always_comb
  begin
    pick = node_data_i[win];
    pick.data.destid = 4'(win);
  end

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      out_v_r <= 1'b0;
      rr_r    <= 1'b0;
    end
    else if (load_ok)
    begin
      out_v_r <= |node_v_i;
      // alternate only on contention
      if (both_v)
      begin
        rr_r <= ~rr_r;
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (load_ok & (|node_v_i))
    begin
      out_data_r <= pick;
    end
  end

  assign asm_v_o    = out_v_r;
  assign asm_data_o = out_data_r;

  // a stalled word holds until the link takes it
  assert property (@(posedge core_clk_i) disable iff (rst_i)
    (asm_v_o && !asm_ready_i) |=> (asm_v_o && $stable(asm_data_o)));

  // never drain two nodes at once
  assert property (@(posedge core_clk_i) disable iff (rst_i)
    $onehot0(node_yumi_o));

endmodule

`default_nettype wire

//--- design/fsb_guts.sv
`default_nettype none

module fsb_guts
  import fsb_pkg::*;
(
  input  logic     core_clk_i,
  input  logic     rst_i,

  // in from the link side
  input  logic     asm_v_i,
  input  fsb_pkt_u asm_data_i,
  output logic     asm_yumi_o,

  // out to the link side
  output logic     asm_v_o,
  output fsb_pkt_u asm_data_o,
  input  logic     asm_ready_i
);

  // dispatcher to nodes
  logic [num_nodes_lp-1:0] node_v_a;
  fsb_pkt_u                node_data_a;
  logic [num_nodes_lp-1:0] node_ready_a;
  fsb_node_ctrl_s          node_ctrl [num_nodes_lp-1:0];

  // nodes to arbiter
  logic [num_nodes_lp-1:0] node_v_b;
  fsb_pkt_u                node_data_b [num_nodes_lp-1:0];
  logic [num_nodes_lp-1:0] node_yumi_b;

  fsb_dispatch dispatch
  (
    .core_clk_i   (core_clk_i),
    .rst_i        (rst_i),
    .asm_v_i      (asm_v_i),
    .asm_data_i   (asm_data_i),
    .asm_yumi_o   (asm_yumi_o),
    .node_v_o     (node_v_a),
    .node_data_o  (node_data_a),
    .node_ready_i (node_ready_a),
    .node_ctrl_o  (node_ctrl)
  );

  // byte sum client
  fsb_sum_node sum_node
  (
    .core_clk_i  (core_clk_i),
    .rst_i       (rst_i),
    .node_ctrl_i (node_ctrl[sum_node_id_lp]),
    .v_i         (node_v_a[sum_node_id_lp]),
    .data_i      (node_data_a),
    .ready_o     (node_ready_a[sum_node_id_lp]),
    .v_o         (node_v_b[sum_node_id_lp]),
    .data_o      (node_data_b[sum_node_id_lp]),
    .yumi_i      (node_yumi_b[sum_node_id_lp])
  );

  // byte reversal client
  fsb_swap_node swap_node
  (
    .core_clk_i  (core_clk_i),
    .rst_i       (rst_i),
    .node_ctrl_i (node_ctrl[swap_node_id_lp]),
    .v_i         (node_v_a[swap_node_id_lp]),
    .data_i      (node_data_a),
    .ready_o     (node_ready_a[swap_node_id_lp]),
    .v_o         (node_v_b[swap_node_id_lp]),
    .data_o      (node_data_b[swap_node_id_lp]),
    .yumi_i      (node_yumi_b[swap_node_id_lp])
  );

  fsb_return_arb return_arb
  (
    .core_clk_i  (core_clk_i),
    .rst_i       (rst_i),
    .node_v_i    (node_v_b),
    .node_data_i (node_data_b),
    .node_yumi_o (node_yumi_b),
    .asm_v_o     (asm_v_o),
    .asm_data_o  (asm_data_o),
    .asm_ready_i (asm_ready_i)
  );

endmodule

`default_nettype wire

//--- dv/fsb_guts_tb.sv
`default_nettype none

module fsb_guts_tb
  import fsb_pkg::*;
();

  localparam int num_stim = 32;
  localparam int cycle_limit = num_stim * 60 + 200;
  localparam logic [31:0] seed = 32'd53347;

  // packets the table below must deliver per node
  // node 1 is disabled before its last two data rows
  localparam int unsigned sum_fwd_total  = 13;
  localparam int unsigned swap_fwd_total = 7;

  // one table row: kind, destid, opcode, back-pressure flag
  typedef struct packed
  {
    logic       is_ctrl;
    logic [3:0] destid;
    logic [2:0] opcode;
    logic       bp;
  } stim_s;

  stim_s stim_table [num_stim] = '{
    // both nodes disabled after reset, data is eaten
    '{1'b0, 4'd0, 3'd0, 1'b0},
    '{1'b0, 4'd1, 3'd0, 1'b0},
    '{1'b1, 4'd0, 3'd1, 1'b0},
    '{1'b1, 4'd1, 3'd1, 1'b0},
    // plain traffic, no stalls
    '{1'b0, 4'd0, 3'd0, 1'b0},
    '{1'b0, 4'd0, 3'd0, 1'b0},
    '{1'b0, 4'd1, 3'd0, 1'b0},
    '{1'b0, 4'd0, 3'd0, 1'b0},
    // interleaved, random ready
    '{1'b0, 4'd0, 3'd0, 1'b1},
    '{1'b0, 4'd1, 3'd0, 1'b1},
    '{1'b0, 4'd1, 3'd0, 1'b1},
    '{1'b0, 4'd0, 3'd0, 1'b1},
    '{1'b0, 4'd0, 3'd0, 1'b1},
    '{1'b0, 4'd1, 3'd0, 1'b1},
    '{1'b0, 4'd0, 3'd0, 1'b1},
    '{1'b0, 4'd1, 3'd0, 1'b1},
    '{1'b0, 4'd1, 3'd0, 1'b1},
    '{1'b0, 4'd1, 3'd0, 1'b1},
    '{1'b0, 4'd0, 3'd0, 1'b1},
    '{1'b0, 4'd0, 3'd0, 1'b1},
    // count restart on node 0
    '{1'b1, 4'd0, 3'd3, 1'b0},
    '{1'b0, 4'd0, 3'd0, 1'b0},
    '{1'b0, 4'd0, 3'd0, 1'b1},
    // node 1 off, then stray destids
    '{1'b1, 4'd1, 3'd2, 1'b0},
    '{1'b0, 4'd1, 3'd0, 1'b1},
    '{1'b0, 4'd2, 3'd0, 1'b0},
    '{1'b1, 4'd2, 3'd2, 1'b0},
    '{1'b0, 4'd0, 3'd0, 1'b1},
    // unknown opcode does nothing
    '{1'b1, 4'd0, 3'd7, 1'b0},
    '{1'b0, 4'd15, 3'd0, 1'b0},
    '{1'b0, 4'd0, 3'd0, 1'b1},
    '{1'b0, 4'd1, 3'd0, 1'b1}
  };

  logic     core_clk;
  logic     rst;
  logic     in_v;
  fsb_pkt_u in_data;
  logic     in_yumi;
  logic     out_v;
  fsb_pkt_u out_data;
  logic     out_ready;

  // reference model state
  logic [num_nodes_lp-1:0] model_en;
  logic [7:0]              model_count;
  fsb_pkt_u                exp_q [num_nodes_lp][$];
  int unsigned             rcv_total [num_nodes_lp];

  logic [31:0] payload_state;
  logic [31:0] ready_state;
  logic        cur_bp;
  logic        stalled;
  fsb_pkt_u    held_pkt;
  logic        take_now;
  int          cycle_count;

  fsb_guts UUT
  (
    .core_clk_i  (core_clk),
    .rst_i       (rst),
    .asm_v_i     (in_v),
    .asm_data_i  (in_data),
    .asm_yumi_o  (in_yumi),
    .asm_v_o     (out_v),
    .asm_data_o  (out_data),
    .asm_ready_i (out_ready)
  );

  initial
  begin
    core_clk = 1'b0;
    forever #20 core_clk = ~core_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] next_payload_byte();
    payload_state = xorshift32(payload_state);
    return payload_state[7:0];
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic compare_pkt(input string what, input fsb_pkt_u expected,
                             input fsb_pkt_u received);
    if (received !== expected)
    begin
      report_failure($sformatf("Error at time %0t: %s expected %h got %h",
                               $time, what, expected, received));
    end
  endtask

  task automatic compare_count(input int node, input int unsigned expected,
                               input int unsigned received);
    if (received !== expected)
    begin
      report_failure($sformatf("Error at time %0t: node %0d sent %0d packets, expected %0d",
                               $time, node, received, expected));
    end
  endtask

  // random header bits and payload, then the fields under test
  function automatic fsb_pkt_u build_packet(input stim_s s);
    logic [ring_bytes_lp-1:0][7:0] raw;
    fsb_pkt_u p;
    for (int b = 0; b < ring_bytes_lp; b++)
    begin
      raw[b] = next_payload_byte();
    end
    p = raw;
    p.data.destid = s.destid;
    p.data.cmd    = s.is_ctrl;
    if (s.is_ctrl)
    begin
      p.ctrl.opcode = fsb_opcode_e'(s.opcode);
    end
    return p;
  endfunction

  // 16-bit byte sum in bytes 0 and 1, count in byte 2
  function automatic fsb_pkt_u sum_result(input fsb_pkt_u p, input logic [7:0] count);
    logic [15:0] total;
    fsb_pkt_u r;
    total = '0;
    for (int i = 0; i < payload_bytes_lp; i++)
    begin
      total = total + {8'd0, p.data.data[i]};
    end
    r = '0;
    r.data.destid  = 4'(sum_node_id_lp);
    r.data.pad     = p.data.pad;
    r.data.data[0] = total[7:0];
    r.data.data[1] = total[15:8];
    r.data.data[2] = count;
    return r;
  endfunction

  function automatic fsb_pkt_u swap_result(input fsb_pkt_u p);
    fsb_pkt_u r;
    r = p;
    r.data.destid = 4'(swap_node_id_lp);
    for (int k = 0; k < payload_bytes_lp; k++)
    begin
      r.data.data[k] = p.data.data[payload_bytes_lp-1-k];
    end
    return r;
  endfunction

  // model update at the edge the hub takes the packet
  task automatic model_accept(input fsb_pkt_u p);
    int node;
    node = int'(p.data.destid);
    if (node < num_nodes_lp)
    begin
      if (p.data.cmd)
      begin
        case (p.ctrl.opcode)
          op_enable:  model_en[node] = 1'b1;
          op_disable: model_en[node] = 1'b0;
          op_reset:   model_count = (node == sum_node_id_lp) ? 8'd0 : model_count;
          default:    model_count = model_count;
        endcase
      end
      else if (model_en[node])
      begin
        if (node == sum_node_id_lp)
        begin
          model_count = model_count + 8'd1;
          exp_q[node].push_back(sum_result(p, model_count));
        end
        else
        begin
          exp_q[node].push_back(swap_result(p));
        end
      end
    end
  endtask

  task automatic receive_pkt(input fsb_pkt_u p);
    int node;
    node = int'(p.data.destid);
    if (node >= num_nodes_lp)
    begin
      report_failure($sformatf("Error at time %0t: output destid %0d has no node",
                               $time, node));
    end
    else if (exp_q[node].size() == 0)
    begin
      report_failure($sformatf("Error at time %0t: unexpected packet %h from node %0d",
                               $time, p, node));
    end
    else
    begin
      compare_pkt($sformatf("node %0d packet", node), exp_q[node].pop_front(), p);
      rcv_total[node]++;
    end
  endtask

  function automatic logic pending();
    return (exp_q[0].size() != 0) || (exp_q[1].size() != 0);
  endfunction

  // output checks, sampled on the rising edge
  always @(posedge core_clk)
  begin
    if (!rst)
    begin
      // held word must survive a stall untouched
      if (stalled)
      begin
        if (!out_v)
        begin
          report_failure($sformatf("Error at time %0t: valid dropped during a stall", $time));
        end
        else
        begin
          compare_pkt("stalled output", held_pkt, out_data);
        end
      end
      stalled  = out_v && !out_ready;
      held_pkt = out_data;
      if (out_v && out_ready)
      begin
        receive_pkt(out_data);
      end
    end
  end

  // link back-pressure, random only for flagged rows
  always @(negedge core_clk)
  begin
    ready_state = xorshift32(ready_state);
    out_ready   = rst | ~cur_bp | ready_state[7];
  end

  initial
  begin
    cycle_count = 0;
    forever
    begin
      @(posedge core_clk);
      cycle_count++;
      if (cycle_count >= cycle_limit)
      begin
        report_failure($sformatf("Timeout: the run did not finish within %0d cycles",
                                 cycle_limit));
      end
    end
  end

  initial
  begin
    rst           = 1'b1;
    in_v          = 1'b0;
    in_data       = '0;
    out_ready     = 1'b1;
    payload_state = seed;
    ready_state   = ~seed;
    model_en      = enabled_at_start_lp;
    model_count   = '0;
    stalled       = 1'b0;
    held_pkt      = '0;
    take_now      = 1'b0;
    rcv_total     = '{0, 0};
    cur_bp        = stim_table[0].bp;
    repeat (5) @(posedge core_clk);
    @(negedge core_clk);
    rst = 1'b0;

    for (int i = 0; i < num_stim; i++)
    begin
      @(negedge core_clk);
      // node reset would drop a word still in flight
      if (stim_table[i].is_ctrl && (stim_table[i].opcode == 3'(op_reset)))
      begin
        while (pending()) @(negedge core_clk);
      end
      in_data = build_packet(stim_table[i]);
      in_v    = 1'b1;
      // control, stray destids and disabled targets drain on the first edge
      take_now = in_data.data.cmd || (in_data.data.destid >= num_nodes_lp)
                 || !model_en[in_data.data.destid[0]];
      @(posedge core_clk);
      if (take_now && !in_yumi)
      begin
        report_failure($sformatf("Error at time %0t: row %0d was not consumed at once",
                                 $time, i));
      end
      while (!in_yumi) @(posedge core_clk);
      model_accept(in_data);
      cur_bp = (i + 1 < num_stim) ? stim_table[(i + 1) % num_stim].bp : 1'b0;
      @(negedge core_clk);
      in_v = 1'b0;
    end

    while (pending()) @(negedge core_clk);
    // nothing extra may trail behind
    repeat (10) @(negedge core_clk);
    compare_count(sum_node_id_lp, sum_fwd_total, rcv_total[sum_node_id_lp]);
    compare_count(swap_node_id_lp, swap_fwd_total, rcv_total[swap_node_id_lp]);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
design/fsb_pkg.sv
design/fsb_dispatch.sv
design/fsb_sum_node.sv
design/fsb_swap_node.sv
design/fsb_return_arb.sv
design/fsb_guts.sv
dv/fsb_guts_tb.sv
